//--- hdl/imagePkg.sv
// All addresses are word addresses and the input image must not overlap the padded frame buffer
package imagePkg;

	// Width types
	typedef logic [25:0] addr_t;
	typedef logic [31:0] data_t;
	typedef logic [7:0] pixel_t;
	typedef logic [1:0] csrAddr_t;
	typedef logic [19:0] count_t;

	// Host register slave request
	typedef struct packed {
		logic chipSelect;
		logic read;
		logic write;
		csrAddr_t address;
		data_t writeData;
	} hostReq_t;

	// Memory master request, held until waitRequest drops
	typedef struct packed {
		logic read;
		logic write;
		addr_t address;
		data_t writeData;
	} memReq_t;

	// Memory response
	typedef struct packed {
		logic waitRequest;
		logic readDataValid;
		data_t readData;
	} memRsp_t;

	// Host handshake codes
	localparam data_t START_BYTE = 32'h0000_0053;
	localparam data_t COPY_BYTE = 32'h0000_0017;
	localparam data_t NEXT_BYTE = 32'h0000_0013;
	localparam data_t LASTPIX_BYTE = 32'h0000_0019;
	localparam data_t STOP_BYTE = 32'h0000_0012;

	// Image regions
	localparam addr_t INPUT_BASE = 26'h240_0000;
	localparam addr_t FRAME_BASE = 26'h200_0000;

	// Pixels above this turn white
	localparam pixel_t THRESHOLD = 8'd100;
	localparam data_t WHITE_WORD = 32'h00FF_FFFF;

	typedef enum logic [0:0] {
		COPY_IDLE,
		COPY_WRITE
	} copyState_t;

	typedef enum logic [1:0] {
		BLIT_IDLE,
		BLIT_READ,
		BLIT_WAIT,
		BLIT_WRITE
	} blitState_t;

	typedef enum logic [1:0] {
		ARB_FREE,
		ARB_COPY,
		ARB_BLIT
	} arbState_t;

endpackage

//--- hdl/csrBlock.sv
// Slave never stalls; a done update that collides with a host write to its register lands a cycle later
`timescale 1ns/1ns

module csrBlock import imagePkg::*;
(
	input logic clk,
	input logic reset_n,
	input hostReq_t host_i,
	input logic copyDone_i,
	input logic frameDone_i,
	input count_t pixelCount_i,
	output data_t hostReadData_o,
	output logic sessionStart_o,
	output logic copyReq_o,
	output data_t pixelWord_o,
	output logic frameStart_o
);

	// Register map
	localparam csrAddr_t CMD_REG = 2'd0;
	localparam csrAddr_t HANDSHAKE_REG = 2'd1;
	localparam csrAddr_t PIXEL_REG = 2'd2;
	localparam csrAddr_t COUNT_REG = 2'd3;

	data_t cmdReg;
	data_t handshakeReg;
	data_t pixelReg;
	data_t readMux;
	logic nextPending;
	logic stopPending;
	logic hostWrite;
	logic hostRead;
	logic cmdWrite;
	logic handshakeWrite;
	logic nextUpdate;
	logic stopUpdate;

	assign hostWrite = host_i.chipSelect && host_i.write;
	assign hostRead = host_i.chipSelect && host_i.read;
	assign cmdWrite = hostWrite && (host_i.address == CMD_REG);
	assign handshakeWrite = hostWrite && (host_i.address == HANDSHAKE_REG);

	// Fresh done pulse or one left over from a lost cycle
	assign nextUpdate = copyDone_i || nextPending;
	assign stopUpdate = frameDone_i || stopPending;

	assign pixelWord_o = pixelReg;

	always_comb
	begin
		case (host_i.address)
			CMD_REG: readMux = cmdReg;
			HANDSHAKE_REG: readMux = handshakeReg;
			PIXEL_REG: readMux = pixelReg;
			COUNT_REG: readMux = data_t'(pixelCount_i);
			default: readMux = '0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!reset_n)
		begin
			cmdReg <= '0;
			handshakeReg <= '0;
			pixelReg <= '0;
			hostReadData_o <= '0;
			nextPending <= 1'b0;
			stopPending <= 1'b0;
			sessionStart_o <= 1'b0;
			copyReq_o <= 1'b0;
			frameStart_o <= 1'b0;
		end
		else
		begin
			// Command pulses, one cycle after the host write
			sessionStart_o <= cmdWrite && (host_i.writeData == START_BYTE);
			copyReq_o <= handshakeWrite && (host_i.writeData == COPY_BYTE);
			frameStart_o <= handshakeWrite && (host_i.writeData == LASTPIX_BYTE);
			// Host write wins, STOP retried next cycle
			if (cmdWrite)
				cmdReg <= host_i.writeData;
			else if (stopUpdate)
				cmdReg <= STOP_BYTE;
			stopPending <= cmdWrite && stopUpdate;
			// Same rule for NEXT on the handshake register
			if (handshakeWrite)
				handshakeReg <= host_i.writeData;
			else if (nextUpdate)
				handshakeReg <= NEXT_BYTE;
			nextPending <= handshakeWrite && nextUpdate;
			if (hostWrite && (host_i.address == PIXEL_REG))
				pixelReg <= host_i.writeData;
			// Read data held until the next read
			if (hostRead)
				hostReadData_o <= readMux;
		end
	end

	// Host access is a read or a write, never both at once
	assert property (@(posedge clk) disable iff (!reset_n)
		!(host_i.chipSelect && host_i.read && host_i.write))
		else $error("host read and write in the same access");

endmodule

//--- hdl/pixelCopier.sv
// One write in flight at a time; a START during a pending write also moves that write's address
`timescale 1ns/1ns

module pixelCopier import imagePkg::*;
(
	input logic clk,
	input logic reset_n,
	input logic sessionStart_i,
	input logic copyReq_i,
	input data_t pixelWord_i,
	input memRsp_t mem_i,
	output memReq_t mem_o,
	output logic copyDone_o
);

	copyState_t copyState;
	addr_t copyAddr;
	data_t wordReg;
	logic writeAccepted;

	assign writeAccepted = (copyState == COPY_WRITE) && !mem_i.waitRequest;

	// Write request straight from state, address and latched word
	always_comb
	begin
		mem_o = '0;
		mem_o.write = (copyState == COPY_WRITE);
		mem_o.address = copyAddr;
		mem_o.writeData = wordReg;
	end

	// Latched pixel, no reset needed
	always_ff @(posedge clk)
	begin
		if (copyReq_i && (copyState == COPY_IDLE))
			wordReg <= pixelWord_i;
	end

	always_ff @(posedge clk)
	begin
		if (!reset_n)
		begin
			copyState <= COPY_IDLE;
			copyAddr <= INPUT_BASE;
			copyDone_o <= 1'b0;
		end
		else
		begin
			copyDone_o <= writeAccepted;
			if (copyState == COPY_IDLE && copyReq_i)
				copyState <= COPY_WRITE;
			else if (writeAccepted)
				copyState <= COPY_IDLE;
			// New session restarts at the image base
			if (sessionStart_i)
				copyAddr <= INPUT_BASE;
			else if (writeAccepted)
				copyAddr <= copyAddr + 1'b1;
		end
	end

	// Stalled write keeps address and data until taken
	assert property (@(posedge clk) disable iff (!reset_n)
		mem_o.write && mem_i.waitRequest |=>
		mem_o.write && $stable(mem_o.address) && $stable(mem_o.writeData))
		else $error("copy request changed under waitRequest");

endmodule

//--- hdl/thresholdBlitter.sv
// Strictly one pixel at a time; frameStart is ignored while a frame is running
`timescale 1ns/1ns

module thresholdBlitter import imagePkg::*;
#(
	parameter int IMG_WIDTH = 640,
	parameter int IMG_HEIGHT = 480,
	parameter int ROW_PAD_WORDS = 2
)
(
	input logic clk,
	input logic reset_n,
	input logic frameStart_i,
	input memRsp_t mem_i,
	output memReq_t mem_o,
	output logic frameDone_o,
	output count_t pixelCount_o
);

	// Geometry in counter and address units
	localparam count_t LAST_PIXEL = count_t'(IMG_WIDTH * IMG_HEIGHT - 1);
	localparam count_t LAST_COL = count_t'(IMG_WIDTH - 1);
	localparam addr_t ROW_STRIDE = addr_t'(IMG_WIDTH + ROW_PAD_WORDS);

	blitState_t blitState;
	addr_t readAddr;
	addr_t rowBase;
	addr_t writeAddr;
	count_t colCount;
	count_t pixelCount;
	data_t resultWord;
	pixel_t pixelValue;
	logic accepted;

	assign pixelValue = mem_i.readData[7:0];
	assign accepted = !mem_i.waitRequest;
	// Row base plus column, padding folded into the row step
	assign writeAddr = rowBase + addr_t'(colCount);
	assign pixelCount_o = pixelCount;

	always_comb
	begin
		mem_o = '0;
		mem_o.read = (blitState == BLIT_READ);
		mem_o.write = (blitState == BLIT_WRITE);
		mem_o.address = (blitState == BLIT_WRITE) ? writeAddr : readAddr;
		mem_o.writeData = resultWord;
	end

	// Thresholded pixel waiting for its write
	always_ff @(posedge clk)
	begin
		if (blitState == BLIT_WAIT && mem_i.readDataValid)
			resultWord <= (pixelValue > THRESHOLD) ? WHITE_WORD : '0;
	end

	always_ff @(posedge clk)
	begin
		if (!reset_n)
		begin
			blitState <= BLIT_IDLE;
			readAddr <= INPUT_BASE;
			rowBase <= FRAME_BASE;
			colCount <= '0;
			pixelCount <= '0;
			frameDone_o <= 1'b0;
		end
		else
		begin
			frameDone_o <= 1'b0;
			case (blitState)
				BLIT_IDLE:
				begin
					if (frameStart_i)
					begin
						readAddr <= INPUT_BASE;
						rowBase <= FRAME_BASE;
						colCount <= '0;
						pixelCount <= '0;
						blitState <= BLIT_READ;
					end
				end
				BLIT_READ:
				begin
					if (accepted)
						blitState <= BLIT_WAIT;
				end
				BLIT_WAIT:
				begin
					if (mem_i.readDataValid)
						blitState <= BLIT_WRITE;
				end
				BLIT_WRITE:
				begin
					if (accepted)
					begin
						pixelCount <= pixelCount + 1'b1;
						readAddr <= readAddr + 1'b1;
						// End of row skips the padding words
						if (colCount == LAST_COL)
						begin
							colCount <= '0;
							rowBase <= rowBase + ROW_STRIDE;
						end
						else
							colCount <= colCount + 1'b1;
						if (pixelCount == LAST_PIXEL)
						begin
							frameDone_o <= 1'b1;
							blitState <= BLIT_IDLE;
						end
						else
							blitState <= BLIT_READ;
					end
				end
				default: blitState <= BLIT_IDLE;
			endcase
		end
	end

endmodule

//--- hdl/memArbiter.sv
// Assumes every read accepted by memory returns exactly one readDataValid
`timescale 1ns/1ns

module memArbiter import imagePkg::*;
(
	input logic clk,
	input logic reset_n,
	input memReq_t copyReq_i,
	input memReq_t blitReq_i,
	input memRsp_t mem_i,
	output memRsp_t copyRsp_o,
	output memRsp_t blitRsp_o,
	output memReq_t mem_o
);

	arbState_t arbState;
	arbState_t grant;
	memReq_t grantedReq;
	logic writeAccepted;

	// Lock holds the owner, free state grants at once with copier first
	always_comb
	begin
		case (arbState)
			ARB_COPY: grant = ARB_COPY;
			ARB_BLIT: grant = ARB_BLIT;
			default:
			begin
				if (copyReq_i.read || copyReq_i.write)
					grant = ARB_COPY;
				else if (blitReq_i.read || blitReq_i.write)
					grant = ARB_BLIT;
				else
					grant = ARB_FREE;
			end
		endcase
	end

	assign grantedReq = (grant == ARB_COPY) ? copyReq_i :
		(grant == ARB_BLIT) ? blitReq_i : '0;
	assign mem_o = grantedReq;
	assign writeAccepted = grantedReq.write && !mem_i.waitRequest;

	// Loser always sees a stall
	assign copyRsp_o.waitRequest = (grant == ARB_COPY) ? mem_i.waitRequest : 1'b1;
	assign blitRsp_o.waitRequest = (grant == ARB_BLIT) ? mem_i.waitRequest : 1'b1;
	// Read data only to the locked owner
	assign copyRsp_o.readDataValid = (arbState == ARB_COPY) && mem_i.readDataValid;
	assign blitRsp_o.readDataValid = (arbState == ARB_BLIT) && mem_i.readDataValid;
	assign copyRsp_o.readData = mem_i.readData;
	assign blitRsp_o.readData = mem_i.readData;

	always_ff @(posedge clk)
	begin
		if (!reset_n)
			arbState <= ARB_FREE;
		else if (arbState == ARB_FREE)
		begin
			// Write taken at once needs no lock
			if (grant != ARB_FREE && !writeAccepted)
				arbState <= grant;
		end
		else if (writeAccepted || mem_i.readDataValid)
			arbState <= ARB_FREE;
	end

	// Read data with no owner would be dropped
	assert property (@(posedge clk) disable iff (!reset_n)
		!(arbState == ARB_FREE && mem_i.readDataValid))
		else $error("readDataValid with no read outstanding");

endmodule

//--- hdl/imageCoprocessor.sv
// Single clock; the host must wait for NEXT before each COPY and for STOP after LASTPIX
`timescale 1ns/1ns

module imageCoprocessor import imagePkg::*;
#(
	parameter int IMG_WIDTH = 640,
	parameter int IMG_HEIGHT = 480,
	parameter int ROW_PAD_WORDS = 2
)
(
	input logic clk,
	input logic reset_n,
	input hostReq_t host_i,
	input memRsp_t mem_i,
	output data_t hostReadData_o,
	output memReq_t mem_o
);

	// CSR to engine handshake
	logic sessionStart;
	logic copyReq;
	data_t pixelWord;
	logic frameStart;
	logic copyDone;
	logic frameDone;
	count_t pixelCount;

	// Engine sides of the arbiter
	memReq_t copyMemReq;
	memRsp_t copyMemRsp;
	memReq_t blitMemReq;
	memRsp_t blitMemRsp;

	csrBlock u_csrBlock (
		.clk(clk),
		.reset_n(reset_n),
		.host_i(host_i),
		.copyDone_i(copyDone),
		.frameDone_i(frameDone),
		.pixelCount_i(pixelCount),
		.hostReadData_o(hostReadData_o),
		.sessionStart_o(sessionStart),
		.copyReq_o(copyReq),
		.pixelWord_o(pixelWord),
		.frameStart_o(frameStart)
	);

	pixelCopier u_pixelCopier (
		.clk(clk),
		.reset_n(reset_n),
		.sessionStart_i(sessionStart),
		.copyReq_i(copyReq),
		.pixelWord_i(pixelWord),
		.mem_i(copyMemRsp),
		.mem_o(copyMemReq),
		.copyDone_o(copyDone)
	);

	thresholdBlitter #(
		.IMG_WIDTH(IMG_WIDTH),
		.IMG_HEIGHT(IMG_HEIGHT),
		.ROW_PAD_WORDS(ROW_PAD_WORDS)
	) u_thresholdBlitter (
		.clk(clk),
		.reset_n(reset_n),
		.frameStart_i(frameStart),
		.mem_i(blitMemRsp),
		.mem_o(blitMemReq),
		.frameDone_o(frameDone),
		.pixelCount_o(pixelCount)
	);

	memArbiter u_memArbiter (
		.clk(clk),
		.reset_n(reset_n),
		.copyReq_i(copyMemReq),
		.blitReq_i(blitMemReq),
		.mem_i(mem_i),
		.copyRsp_o(copyMemRsp),
		.blitRsp_o(blitMemRsp),
		.mem_o(mem_o)
	);

endmodule

//--- verification/frameChecker.sv
// One session and one frame per reset; reads of registers 0 and 1 also accept STOP or NEXT once due
`timescale 1ns/1ns

module frameChecker import imagePkg::*;
#(
	parameter int IMG_WIDTH = 8,
	parameter int IMG_HEIGHT = 4,
	parameter int ROW_PAD_WORDS = 2
)
(
	input logic clk,
	input logic reset_n,
	input hostReq_t host_i,
	input data_t hostReadData_i,
	input memReq_t mem_i,
	input memRsp_t memRsp_i,
	input logic finalCheck_i,
	output int errorCount_o,
	output int checkCount_o
);

	localparam int PIXELS = IMG_WIDTH * IMG_HEIGHT;
	localparam int STRIDE = IMG_WIDTH + ROW_PAD_WORDS;
	localparam int FRAME_WORDS = IMG_HEIGHT * STRIDE;

	// Host side register model
	data_t regModel [4];
	// Pixels sent by the host, and what the DUT wrote
	data_t expInput [PIXELS];
	data_t obsInput [PIXELS];
	data_t obsFrame [FRAME_WORDS];
	logic frameWritten [FRAME_WORDS];
	int copyCmds;
	int copyWrites;
	int frameWrites;
	int readsDone;
	logic frameStarted;
	logic nextDue;
	logic resetSeen;
	logic readPending;
	logic altAllowed;
	data_t readExpected;
	data_t readAlt;

	// Threshold rule, white above 100
	function automatic data_t thresholdWord(input data_t word);
		return (word[7:0] > 8'd100) ? 32'h00FF_FFFF : 32'h0000_0000;
	endfunction

	// Frame offset of pixel k past the padding of earlier rows
	function automatic int frameOffset(input int k);
		return (k / IMG_WIDTH) * STRIDE + (k % IMG_WIDTH);
	endfunction

	task automatic checkThat(input logic ok, input string msg);
		checkCount_o++;
		if (!ok)
		begin
			errorCount_o++;
			$display("FAIL at %0t ns: %s", $time, msg);
		end
	endtask

	// Expected read data fixed at the accepting edge
	task automatic trackHost();
		if (host_i.read)
		begin
			readPending = 1'b1;
			altAllowed = 1'b0;
			readAlt = '0;
			case (host_i.address)
				2'd0:
				begin
					readExpected = regModel[0];
					readAlt = STOP_BYTE;
					altAllowed = (frameWrites == PIXELS);
				end
				2'd1:
				begin
					readExpected = regModel[1];
					readAlt = NEXT_BYTE;
					altAllowed = nextDue;
				end
				2'd2: readExpected = regModel[2];
				default: readExpected = data_t'(frameWrites);
			endcase
		end
		if (host_i.write)
		begin
			regModel[host_i.address] = host_i.writeData;
			if (host_i.address == 2'd1)
			begin
				nextDue = 1'b0;
				if (host_i.writeData == COPY_BYTE && copyCmds < PIXELS)
				begin
					expInput[copyCmds] = regModel[2];
					copyCmds++;
				end
				if (host_i.writeData == LASTPIX_BYTE)
					frameStarted = 1'b1;
			end
		end
	endtask

	// Accepted memory transfers in order
	task automatic checkMemory();
		int offset;
		if (mem_i.read)
		begin
			checkThat(frameStarted, "memory read before LASTPIX");
			checkThat(mem_i.address == INPUT_BASE + addr_t'(readsDone),
				$sformatf("read address %h, expected pixel %0d", mem_i.address, readsDone));
			readsDone++;
		end
		else if (mem_i.address >= INPUT_BASE && mem_i.address < INPUT_BASE + addr_t'(PIXELS))
		begin
			offset = int'(mem_i.address - INPUT_BASE);
			if (copyWrites < copyCmds)
				checkThat(offset == copyWrites && mem_i.writeData == expInput[copyWrites],
					$sformatf("copy write %0d at offset %0d data %h", copyWrites, offset,
					mem_i.writeData));
			else
				checkThat(1'b0, "copy write with no COPY command pending");
			obsInput[offset] = mem_i.writeData;
			copyWrites++;
			nextDue = 1'b1;
		end
		else if (mem_i.address >= FRAME_BASE &&
			mem_i.address < FRAME_BASE + addr_t'(FRAME_WORDS))
		begin
			offset = int'(mem_i.address - FRAME_BASE);
			if (frameStarted && frameWrites < PIXELS)
				checkThat(offset == frameOffset(frameWrites) &&
					mem_i.writeData == thresholdWord(expInput[frameWrites]),
					$sformatf("frame write %0d at offset %0d data %h", frameWrites, offset,
					mem_i.writeData));
			else
				checkThat(1'b0, "frame write outside the processing phase");
			obsFrame[offset] = mem_i.writeData;
			frameWritten[offset] = 1'b1;
			frameWrites++;
		end
		else
			checkThat(1'b0, $sformatf("write to unexpected address %h", mem_i.address));
	endtask

	// Whole images rebuilt from offsets, padding must stay untouched
	task automatic compareImages();
		checkThat(copyWrites == PIXELS && frameWrites == PIXELS,
			$sformatf("%0d copy and %0d frame writes", copyWrites, frameWrites));
		for (int k = 0; k < copyCmds; k++)
			checkThat(obsInput[k] === expInput[k], $sformatf("input word %0d differs", k));
		for (int w = 0; w < FRAME_WORDS; w++)
		begin
			if (w % STRIDE >= IMG_WIDTH)
				checkThat(!frameWritten[w], $sformatf("padding word %0d was written", w));
			else
				checkThat(frameWritten[w] && obsFrame[w] ==
					thresholdWord(expInput[(w / STRIDE) * IMG_WIDTH + w % STRIDE]),
					$sformatf("frame word %0d missing or wrong", w));
		end
	endtask

	always @(posedge clk)
	begin
		if (!reset_n)
		begin
			foreach (regModel[i])
				regModel[i] = '0;
			foreach (frameWritten[i])
				frameWritten[i] = 1'b0;
			copyCmds = 0;
			copyWrites = 0;
			frameWrites = 0;
			readsDone = 0;
			frameStarted = 1'b0;
			nextDue = 1'b0;
			resetSeen = 1'b0;
			readPending = 1'b0;
			errorCount_o = 0;
			checkCount_o = 0;
		end
		else
		begin
			if (!resetSeen)
			begin
				checkThat(!mem_i.read && !mem_i.write, "memory request active after reset");
				resetSeen = 1'b1;
			end
			// Data of the read accepted one edge ago
			if (readPending)
				checkThat(hostReadData_i == readExpected ||
					(altAllowed && hostReadData_i == readAlt),
					$sformatf("host read %h, expected %h", hostReadData_i, readExpected));
			readPending = 1'b0;
			if (host_i.chipSelect)
				trackHost();
			if ((mem_i.read || mem_i.write) && !memRsp_i.waitRequest)
				checkMemory();
			if (finalCheck_i)
				compareImages();
		end
	end

endmodule

//--- verification/tbTop.sv
// Runs one copy session and one 8x4 frame with two padding words per row after a single reset
`timescale 1ns/1ns

module tbTop import imagePkg::*; ();

	localparam int CLK_PERIOD = 40;
	localparam int IMG_WIDTH = 8;
	localparam int IMG_HEIGHT = 4;
	localparam int ROW_PAD_WORDS = 2;
	localparam int PIXELS = IMG_WIDTH * IMG_HEIGHT;
	localparam int WATCHDOG_CYCLES = 200 * PIXELS;
	localparam logic [31:0] SEED = 32'h16b58ff0;

	logic clk = 1'b0;
	logic reset_n = 1'b0;
	hostReq_t host = '0;
	memRsp_t memRsp = '0;
	data_t hostReadData;
	memReq_t memReq;
	logic finalCheck = 1'b0;
	int errorCount;
	int checkCount;
	int lastErrors = 0;
	int testNumber = 1;
	// Separate streams for host stimulus and memory timing
	logic [31:0] stimState = SEED;
	logic [31:0] memState = ~SEED;
	data_t memory [addr_t];
	logic readBusy = 1'b0;
	logic [2:0] readDelay = '0;
	data_t readWord = '0;

	function automatic logic [31:0] lcgNext(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// Unwritten words return a pattern of the full address
	function automatic data_t fillWord(input addr_t address);
		return {6'h15, address} ^ 32'hC3A5_0000;
	endfunction

	initial
	begin
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	imageCoprocessor #(
		.IMG_WIDTH(IMG_WIDTH),
		.IMG_HEIGHT(IMG_HEIGHT),
		.ROW_PAD_WORDS(ROW_PAD_WORDS)
	) u_imageCoprocessor (
		.clk(clk),
		.reset_n(reset_n),
		.host_i(host),
		.mem_i(memRsp),
		.hostReadData_o(hostReadData),
		.mem_o(memReq)
	);

	frameChecker #(
		.IMG_WIDTH(IMG_WIDTH),
		.IMG_HEIGHT(IMG_HEIGHT),
		.ROW_PAD_WORDS(ROW_PAD_WORDS)
	) u_frameChecker (
		.clk(clk),
		.reset_n(reset_n),
		.host_i(host),
		.hostReadData_i(hostReadData),
		.mem_i(memReq),
		.memRsp_i(memRsp),
		.finalCheck_i(finalCheck),
		.errorCount_o(errorCount),
		.checkCount_o(checkCount)
	);

	// Memory with random stalls and 1 to 4 cycle read latency
	always @(posedge clk)
	begin
		if (!reset_n)
		begin
			memRsp <= '0;
			readBusy <= 1'b0;
		end
		else
		begin
			memState = lcgNext(memState);
			memRsp.readDataValid <= 1'b0;
			if (readBusy)
			begin
				if (readDelay == 3'd1)
				begin
					memRsp.readDataValid <= 1'b1;
					memRsp.readData <= readWord;
					readBusy <= 1'b0;
				end
				else
					readDelay <= readDelay - 3'd1;
			end
			else if (memReq.read && !memRsp.waitRequest)
			begin
				readBusy <= 1'b1;
				readDelay <= {1'b0, memState[25:24]} + 3'd1;
				readWord <= memory.exists(memReq.address) ? memory[memReq.address] :
					fillWord(memReq.address);
			end
			if (memReq.write && !memRsp.waitRequest)
				memory[memReq.address] = memReq.writeData;
			memRsp.waitRequest <= memState[31];
		end
	end

	// Single host write, accepted on the next edge
	task automatic hostWrite(input csrAddr_t address, input data_t value);
		@(posedge clk);
		host <= '{chipSelect: 1'b1, read: 1'b0, write: 1'b1, address: address, writeData: value};
		@(posedge clk);
		host <= '0;
	endtask

	// Read data is taken one edge after acceptance
	task automatic hostRead(input csrAddr_t address, output data_t value);
		@(posedge clk);
		host <= '{chipSelect: 1'b1, read: 1'b1, write: 1'b0, address: address, writeData: '0};
		@(posedge clk);
		host <= '0;
		@(posedge clk);
		value = hostReadData;
	endtask

	// Let the checker settle, then sample counts away from the edge
	task automatic reportTest(input string name);
		repeat (2) @(posedge clk);
		@(negedge clk);
		if (errorCount == lastErrors)
			$display("Test %0d %s: ok", testNumber, name);
		else
			$display("Test %0d %s: %0d errors", testNumber, name, errorCount - lastErrors);
		lastErrors = errorCount;
		testNumber++;
	endtask

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Timeout: run still busy after %0d cycles", WATCHDOG_CYCLES);
		$display("Done: errors found");
		$finish;
	end

	initial
	begin
		data_t value;
		reset_n <= 1'b0;
		repeat (10) @(posedge clk);
		reset_n <= 1'b1;
		// Registers all zero out of reset
		for (int r = 0; r < 4; r++)
			hostRead(csrAddr_t'(r), value);
		reportTest("reset state");
		stimState = lcgNext(stimState);
		hostWrite(2'd2, stimState);
		hostRead(2'd2, value);
		reportTest("pixel register readback");
		// Copy phase, one pixel per NEXT
		hostWrite(2'd0, START_BYTE);
		for (int k = 0; k < PIXELS; k++)
		begin
			stimState = lcgNext(stimState);
			hostWrite(2'd2, stimState);
			hostWrite(2'd1, COPY_BYTE);
			do
				hostRead(2'd1, value);
			while (value != NEXT_BYTE);
		end
		reportTest("pixel copy");
		hostWrite(2'd1, LASTPIX_BYTE);
		do
			hostRead(2'd0, value);
		while (value != STOP_BYTE);
		reportTest("threshold frame");
		hostRead(2'd3, value);
		reportTest("stop and count");
		@(posedge clk);
		finalCheck <= 1'b1;
		@(posedge clk);
		finalCheck <= 1'b0;
		reportTest("memory image");
		$display("Tests: %0d, checks: %0d, errors: %0d", testNumber - 1, checkCount, errorCount);
		if (errorCount == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

//--- vlog.f
hdl/imagePkg.sv
hdl/csrBlock.sv
hdl/pixelCopier.sv
hdl/thresholdBlitter.sv
hdl/memArbiter.sv
hdl/imageCoprocessor.sv
verification/frameChecker.sv
verification/tbTop.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator, fail on build error or fail message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tbTop -f vlog.f -o simTop
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/simTop > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Done: errors found" sim.log; then
	exit 1
fi
if ! grep -q "Done: no errors" sim.log; then
	echo "Simulation ended without a result"
	exit 1
fi
exit 0
